// File: Bender.yml
package:
  name: dcache

sources:
  - hdl/dcache_pkg.sv
  - hdl/dcache_tag_ram.sv
  - hdl/dcache_data_ram.sv
  - hdl/dcache_line_merge.sv
  - hdl/dcache_ctrl.sv
  - hdl/dcache_top.sv
  - target: test
    files:
      - testbench/dcache_checker.sv
      - testbench/dcache_tb.sv

// File: files.f
hdl/dcache_pkg.sv
hdl/dcache_tag_ram.sv
hdl/dcache_data_ram.sv
hdl/dcache_line_merge.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
testbench/dcache_checker.sv
testbench/dcache_tb.sv

// File: hdl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                                       clk,
    input  logic                                       rst,
    // cpu request
    input  logic                                       req_i,
    input  dcache_pkg::addr_t                          addr_i,
    input  dcache_pkg::strb_t                          wstrb_i,
    input  dcache_pkg::word_t                          wdata_i,
    output logic                                       ready_o,
    output logic                                       data_ok_o,
    output dcache_pkg::word_t                          rdata_o,
    // ram read side
    input  dcache_pkg::tag_t [dcache_pkg::NWAY-1:0]    rd_tag_i,
    input  dcache_pkg::way_sel_t                       rd_valid_i,
    input  dcache_pkg::way_sel_t                       rd_dirty_i,
    input  dcache_pkg::line_t [dcache_pkg::NWAY-1:0]   rd_data_i,
    output dcache_pkg::index_t                         rd_index_o,
    // ram write side
    output dcache_pkg::way_sel_t                       wr_way_o,
    output dcache_pkg::index_t                         wr_index_o,
    output dcache_pkg::tag_t                           wr_tag_o,
    output logic                                       wr_valid_o,
    output logic                                       wr_dirty_o,
    output dcache_pkg::line_strb_t                     wr_be_o,
    output dcache_pkg::line_t                          wr_data_o,
    // line merge
    input  dcache_pkg::line_t                          merge_line_i,
    input  dcache_pkg::line_strb_t                     merge_be_i,
    output dcache_pkg::line_t                          merge_base_o,
    output logic [1:0]                                 merge_offset_o,
    output dcache_pkg::strb_t                          merge_wstrb_o,
    output dcache_pkg::word_t                          merge_wdata_o,
    // memory port
    output logic                                       mem_req_o,
    output logic                                       mem_we_o,
    output dcache_pkg::addr_t                          mem_addr_o,
    output dcache_pkg::line_t                          mem_wdata_o,
    input  logic                                       mem_ack_i,
    input  dcache_pkg::line_t                          mem_rdata_i
);

    dcache_pkg::ctrl_state_e state_q, state_d;

    dcache_pkg::addr_t req_addr_q;
    dcache_pkg::strb_t req_wstrb_q;
    dcache_pkg::word_t req_wdata_q;
    dcache_pkg::index_t req_index;
    dcache_pkg::tag_t req_tag;
    logic is_store;

    dcache_pkg::way_sel_t hit_way, victim_way, victim_q;
    dcache_pkg::line_t hit_line, victim_line;
    dcache_pkg::tag_t victim_tag;
    logic hit, victim_dirty, victim_found;
    logic [15:0] lfsr_q;

    assign req_index = req_addr_q[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH];
    assign req_tag = req_addr_q[dcache_pkg::ADDR_WIDTH-1 -: dcache_pkg::TAG_WIDTH];
    assign is_store = |req_wstrb_q;

    // request capture, payload only
    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::IDLE && req_i) begin
            req_addr_q <= addr_i;
            req_wstrb_q <= wstrb_i;
            req_wdata_q <= wdata_i;
        end
        if (state_q == dcache_pkg::LOOKUP) begin
            victim_q <= victim_way;
        end
    end

    // ram is read with the incoming address while idle, then held on the request
    assign rd_index_o = (state_q == dcache_pkg::IDLE)
        ? addr_i[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH] : req_index;

    // tag compare and victim pick
    always_comb begin
        hit_line = '0;
        victim_way = '0;
        victim_found = 1'b0;
        for (int w = 0; w < dcache_pkg::NWAY; w++) begin
            hit_way[w] = rd_valid_i[w] && (rd_tag_i[w] == req_tag);
            if (hit_way[w]) begin
                hit_line = rd_data_i[w];
            end
            if (!rd_valid_i[w] && !victim_found) begin
                victim_way[w] = 1'b1;
                victim_found = 1'b1;
            end
        end
        // all ways valid, random way
        if (!victim_found) begin
            victim_way = dcache_pkg::way_sel_t'(1) << lfsr_q[0];
        end
    end

    assign hit = |hit_way;
    assign victim_dirty = |(victim_way & rd_valid_i & rd_dirty_i);

    // victim line and tag for the write-back
    always_comb begin
        victim_line = '0;
        victim_tag = '0;
        for (int w = 0; w < dcache_pkg::NWAY; w++) begin
            if (victim_q[w]) begin
                victim_line = rd_data_i[w];
                victim_tag = rd_tag_i[w];
            end
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= 16'hace1;
        end else begin
            lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= dcache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (req_i) begin
                    state_d = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                if (hit) begin
                    state_d = dcache_pkg::IDLE;
                end else if (victim_dirty) begin
                    state_d = dcache_pkg::WRITEBACK_REQ;
                end else begin
                    state_d = dcache_pkg::REFILL_REQ;
                end
            end
            dcache_pkg::WRITEBACK_REQ: state_d = dcache_pkg::WRITEBACK_WAIT;
            dcache_pkg::WRITEBACK_WAIT: begin
                if (mem_ack_i) begin
                    state_d = dcache_pkg::REFILL_REQ;
                end
            end
            dcache_pkg::REFILL_REQ: state_d = dcache_pkg::REFILL_WAIT;
            dcache_pkg::REFILL_WAIT: begin
                if (mem_ack_i) begin
                    state_d = dcache_pkg::IDLE;
                end
            end
            default: state_d = dcache_pkg::IDLE;
        endcase
    end

    // ram writes: store hit in lookup, full line on refill
    always_comb begin
        wr_way_o = '0;
        wr_valid_o = 1'b0;
        wr_dirty_o = 1'b0;
        wr_be_o = '0;
        merge_base_o = hit_line;
        if (state_q == dcache_pkg::LOOKUP) begin
            if (hit && is_store) begin
                wr_way_o = hit_way;
                wr_valid_o = 1'b1;
                wr_dirty_o = 1'b1;
                wr_be_o = merge_be_i;
            end
        end else if (state_q == dcache_pkg::REFILL_WAIT) begin
            merge_base_o = mem_rdata_i;
            if (mem_ack_i) begin
                wr_way_o = victim_q;
                wr_valid_o = 1'b1;
                wr_dirty_o = is_store;
                wr_be_o = '1;
            end
        end
    end

    assign wr_index_o = req_index;
    assign wr_tag_o = req_tag;
    assign wr_data_o = merge_line_i;

    assign merge_offset_o = req_addr_q[dcache_pkg::OFFSET_WIDTH-1 -: 2];
    assign merge_wstrb_o = req_wstrb_q;
    assign merge_wdata_o = req_wdata_q;

    // cpu response
    assign ready_o = (state_q == dcache_pkg::IDLE);
    assign data_ok_o = (state_q == dcache_pkg::LOOKUP && hit)
        || (state_q == dcache_pkg::REFILL_WAIT && mem_ack_i);
    assign rdata_o = merge_line_i[merge_offset_o*32 +: 32];

    // memory request, one cycle in each request state
    assign mem_req_o = (state_q == dcache_pkg::WRITEBACK_REQ)
        || (state_q == dcache_pkg::REFILL_REQ);
    assign mem_we_o = (state_q == dcache_pkg::WRITEBACK_REQ);
    assign mem_addr_o = mem_we_o
        ? {victim_tag, req_index, {dcache_pkg::OFFSET_WIDTH{1'b0}}}
        : {req_tag, req_index, {dcache_pkg::OFFSET_WIDTH{1'b0}}};
    assign mem_wdata_o = victim_line;

endmodule

// File: hdl/dcache_data_ram.sv
`timescale 1ns/1ps

module dcache_data_ram (
    input  logic                                        clk,
    input  dcache_pkg::way_sel_t                        wr_way_i,
    input  dcache_pkg::index_t                          rd_index_i,
    input  dcache_pkg::index_t                          wr_index_i,
    input  dcache_pkg::line_strb_t                      wr_be_i,
    input  dcache_pkg::line_t                           wr_data_i,
    output dcache_pkg::line_t [dcache_pkg::NWAY-1:0]    rd_data_o
);

    localparam int NBYTES = dcache_pkg::LINE_WIDTH / 8;

    // one bank per way
    for (genvar w = 0; w < dcache_pkg::NWAY; w++) begin : g_way
        dcache_pkg::line_t line_mem [dcache_pkg::NSET];

        // byte lanes written only where enabled
        always_ff @(posedge clk) begin
            if (wr_way_i[w]) begin
                for (int b = 0; b < NBYTES; b++) begin
                    if (wr_be_i[b]) begin
                        line_mem[wr_index_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
                    end
                end
            end
        end

        // registered read port
        always_ff @(posedge clk) begin
            rd_data_o[w] <= line_mem[rd_index_i];
        end
    end

endmodule

// File: hdl/dcache_line_merge.sv
`timescale 1ns/1ps

module dcache_line_merge (
    input  dcache_pkg::line_t        base_line_i,
    input  logic [1:0]               offset_i,
    input  dcache_pkg::strb_t        wstrb_i,
    input  dcache_pkg::word_t        wdata_i,
    output dcache_pkg::line_t        line_o,
    output dcache_pkg::line_strb_t   line_be_o
);

    always_comb begin
        line_o = base_line_i;
        line_be_o = '0;
        for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
            // only the addressed word takes the store bytes
            if (offset_i == w[1:0]) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb_i[b]) begin
                        line_o[w*32 + b*8 +: 8] = wdata_i[b*8 +: 8];
                        line_be_o[w*4 + b] = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: hdl/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int ADDR_WIDTH = 32;
    localparam int NWAY = 2;
    // few sets so that conflicting tags appear early
    localparam int NSET = 16;
    localparam int LINE_WIDTH = 128;
    localparam int WORDS_PER_LINE = LINE_WIDTH / 32;

    // address split: tag | index | byte offset
    localparam int OFFSET_WIDTH = $clog2(LINE_WIDTH / 8);
    localparam int INDEX_WIDTH = $clog2(NSET);
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // cpu side
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] strb_t;

    // line storage
    typedef logic [LINE_WIDTH-1:0] line_t;
    typedef logic [LINE_WIDTH/8-1:0] line_strb_t;

    // tag array
    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;

    // one bit per way
    typedef logic [NWAY-1:0] way_sel_t;

    // lookup and miss handling
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK_REQ,
        WRITEBACK_WAIT,
        REFILL_REQ,
        REFILL_WAIT
    } ctrl_state_e;

endpackage

// File: hdl/dcache_tag_ram.sv
`timescale 1ns/1ps

module dcache_tag_ram (
    input  logic                                       clk,
    input  logic                                       rst,
    input  dcache_pkg::index_t                         rd_index_i,
    input  dcache_pkg::way_sel_t                       wr_way_i,
    input  dcache_pkg::index_t                         wr_index_i,
    input  dcache_pkg::tag_t                           wr_tag_i,
    input  logic                                       wr_valid_i,
    input  logic                                       wr_dirty_i,
    output dcache_pkg::tag_t [dcache_pkg::NWAY-1:0]    rd_tag_o,
    output dcache_pkg::way_sel_t                       rd_valid_o,
    output dcache_pkg::way_sel_t                       rd_dirty_o
);

    dcache_pkg::tag_t tag_mem [dcache_pkg::NWAY][dcache_pkg::NSET];
    logic dirty_mem [dcache_pkg::NWAY][dcache_pkg::NSET];
    logic [dcache_pkg::NSET-1:0] valid_q [dcache_pkg::NWAY];

    // tag and dirty bits, plain storage
    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::NWAY; w++) begin
            if (wr_way_i[w]) begin
                tag_mem[w][wr_index_i] <= wr_tag_i;
                dirty_mem[w][wr_index_i] <= wr_dirty_i;
            end
            rd_tag_o[w] <= tag_mem[w][rd_index_i];
            rd_dirty_o[w] <= dirty_mem[w][rd_index_i];
        end
    end

    // valid bits start cleared
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < dcache_pkg::NWAY; w++) begin
                valid_q[w] <= '0;
            end
            rd_valid_o <= '0;
        end else begin
            for (int w = 0; w < dcache_pkg::NWAY; w++) begin
                if (wr_way_i[w]) begin
                    valid_q[w][wr_index_i] <= wr_valid_i;
                end
                // old value when the same set is written at this edge
                rd_valid_o[w] <= valid_q[w][rd_index_i];
            end
        end
    end

endmodule

// File: hdl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_i,
    input  dcache_pkg::addr_t   addr_i,
    input  dcache_pkg::strb_t   wstrb_i,
    input  dcache_pkg::word_t   wdata_i,
    output logic                ready_o,
    output logic                data_ok_o,
    output dcache_pkg::word_t   rdata_o,
    output logic                mem_req_o,
    output logic                mem_we_o,
    output dcache_pkg::addr_t   mem_addr_o,
    output dcache_pkg::line_t   mem_wdata_o,
    input  logic                mem_ack_i,
    input  dcache_pkg::line_t   mem_rdata_i
);

    dcache_pkg::tag_t [dcache_pkg::NWAY-1:0] rd_tag;
    dcache_pkg::way_sel_t rd_valid, rd_dirty;
    dcache_pkg::line_t [dcache_pkg::NWAY-1:0] rd_data;
    dcache_pkg::index_t rd_index, wr_index;
    dcache_pkg::way_sel_t wr_way;
    dcache_pkg::tag_t wr_tag;
    logic wr_valid, wr_dirty;
    dcache_pkg::line_strb_t wr_be, merge_be;
    dcache_pkg::line_t wr_data, merge_base, merge_line;
    logic [1:0] merge_offset;
    dcache_pkg::strb_t merge_wstrb;
    dcache_pkg::word_t merge_wdata;

    dcache_tag_ram u_tag_ram (
        .clk        (clk),
        .rst        (rst),
        .rd_index_i (rd_index),
        .wr_way_i   (wr_way),
        .wr_index_i (wr_index),
        .wr_tag_i   (wr_tag),
        .wr_valid_i (wr_valid),
        .wr_dirty_i (wr_dirty),
        .rd_tag_o   (rd_tag),
        .rd_valid_o (rd_valid),
        .rd_dirty_o (rd_dirty)
    );

    dcache_data_ram u_data_ram (
        .clk        (clk),
        .wr_way_i   (wr_way),
        .rd_index_i (rd_index),
        .wr_index_i (wr_index),
        .wr_be_i    (wr_be),
        .wr_data_i  (wr_data),
        .rd_data_o  (rd_data)
    );

    dcache_line_merge u_line_merge (
        .base_line_i (merge_base),
        .offset_i    (merge_offset),
        .wstrb_i     (merge_wstrb),
        .wdata_i     (merge_wdata),
        .line_o      (merge_line),
        .line_be_o   (merge_be)
    );

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_i          (req_i),
        .addr_i         (addr_i),
        .wstrb_i        (wstrb_i),
        .wdata_i        (wdata_i),
        .ready_o        (ready_o),
        .data_ok_o      (data_ok_o),
        .rdata_o        (rdata_o),
        .rd_tag_i       (rd_tag),
        .rd_valid_i     (rd_valid),
        .rd_dirty_i     (rd_dirty),
        .rd_data_i      (rd_data),
        .rd_index_o     (rd_index),
        .wr_way_o       (wr_way),
        .wr_index_o     (wr_index),
        .wr_tag_o       (wr_tag),
        .wr_valid_o     (wr_valid),
        .wr_dirty_o     (wr_dirty),
        .wr_be_o        (wr_be),
        .wr_data_o      (wr_data),
        .merge_line_i   (merge_line),
        .merge_be_i     (merge_be),
        .merge_base_o   (merge_base),
        .merge_offset_o (merge_offset),
        .merge_wstrb_o  (merge_wstrb),
        .merge_wdata_o  (merge_wdata),
        .mem_req_o      (mem_req_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_ack_i      (mem_ack_i),
        .mem_rdata_i    (mem_rdata_i)
    );

endmodule

// File: testbench/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker (
    input logic clk,
    input logic rst,
    input logic req_i,
    input logic ready_i,
    input logic data_ok_i,
    input logic mem_req_i,
    input logic mem_ack_i
);

    // one memory request in flight until its ack
    logic outstanding_q;

    // assertion failures so far
    int unsigned fail_cnt = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding_q <= 1'b0;
        end else if (mem_req_i) begin
            outstanding_q <= 1'b1;
        end else if (mem_ack_i) begin
            outstanding_q <= 1'b0;
        end
    end

    a_ok_not_ready: assert property (@(posedge clk) disable iff (rst) data_ok_i |-> !ready_i)
        else begin
            $error("data_ok_o high while ready_o high");
            fail_cnt++;
        end

    a_single_mem_req: assert property (@(posedge clk) disable iff (rst)
        mem_req_i |-> !outstanding_q)
        else begin
            $error("mem_req_o raised again before mem_ack_i");
            fail_cnt++;
        end

    // requester only pulses while the cache is idle
    a_req_when_ready: assert property (@(posedge clk) disable iff (rst) req_i |-> ready_i)
        else begin
            $error("req_i high while ready_o low");
            fail_cnt++;
        end

endmodule

// File: testbench/dcache_input.txt
# op test addr strb wdata expect, all but op and test in hex
# op L is a load, S a store; expect is unused for stores
L 1 00000010 0 00000000 13121110
L 1 00000020 0 00000000 23222120
L 1 00000130 0 00000000 22232021
L 2 00000010 0 00000000 13121110
L 2 00000024 0 00000000 27262524
L 2 0000013c 0 00000000 2e2f2c2d
S 3 00000014 1 123456aa 00000000
S 3 00000018 c beef5555 00000000
S 3 0000001c f cafef00d 00000000
S 3 00000010 2 0000c300 00000000
L 3 00000014 0 00000000 171615aa
L 3 00000018 0 00000000 beef1918
L 3 0000001c 0 00000000 cafef00d
L 3 00000010 0 00000000 1312c310
S 4 00000244 3 9999abcd 00000000
L 4 00000244 0 00000000 6564abcd
S 4 00000358 8 77000000 00000000
L 4 00000358 0 00000000 77696a6b
S 5 00000100 f 11112222 00000000
S 5 00000204 f 33334444 00000000
L 5 00000308 0 00000000 38393a3b
L 5 00000100 0 00000000 11112222
L 5 00000204 0 00000000 33334444
L 5 00000308 0 00000000 38393a3b
L 6 00000064 0 00000000 67666564
S 6 00000168 1 000000e1 00000000
L 6 00000268 0 00000000 49484b4a
L 6 00000168 0 00000000 7a7b78e1
S 6 0000007c c 5a5a0000 00000000
S 6 00000134 f 0badf00d 00000000
L 6 00000170 0 00000000 62636061
L 6 00000270 0 00000000 51505352
L 6 0000007c 0 00000000 5a5a7d7c
L 6 00000134 0 00000000 0badf00d

// File: testbench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    localparam int MEM_BYTES = 4096;
    localparam int MAX_OPS = 64;
    localparam int CYCLES_PER_OP = 30;

    logic clk;
    logic rst;
    logic req, ready, data_ok, mem_req, mem_we, mem_ack;
    dcache_pkg::addr_t addr, mem_addr;
    dcache_pkg::strb_t wstrb;
    dcache_pkg::word_t wdata, rdata;
    dcache_pkg::line_t mem_wdata, mem_rdata;

    // memory model and architectural reference
    logic [7:0] mem [MEM_BYTES];
    logic [7:0] gold [MEM_BYTES];

    logic [7:0] op_kind [MAX_OPS];
    int op_test [MAX_OPS];
    dcache_pkg::addr_t op_addr [MAX_OPS];
    dcache_pkg::strb_t op_strb [MAX_OPS];
    dcache_pkg::word_t op_wdata [MAX_OPS];
    dcache_pkg::word_t op_expect [MAX_OPS];
    int n_ops;

    int seed = 49581;
    int cycle_cnt, cycle_limit;
    int errors, n_loads, tests_passed, tests_failed;
    int cur_op, op_reads, op_writes;
    int test_ops, test_errors, test_writebacks;
    logic mem_busy, pend_we;
    int mem_wait;
    dcache_pkg::addr_t pend_addr;
    dcache_pkg::line_t pend_wdata;

    dcache_top u_dcache_top (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req),
        .addr_i      (addr),
        .wstrb_i     (wstrb),
        .wdata_i     (wdata),
        .ready_o     (ready),
        .data_ok_o   (data_ok),
        .rdata_o     (rdata),
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_ack_i   (mem_ack),
        .mem_rdata_i (mem_rdata)
    );

    bind dcache_top dcache_checker u_dcache_checker (
        .clk       (clk),
        .rst       (rst),
        .req_i     (req_i),
        .ready_i   (ready_o),
        .data_ok_i (data_ok_o),
        .mem_req_i (mem_req_o),
        .mem_ack_i (mem_ack_i)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, the cache stopped completing requests", cycle_cnt);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic flag_mismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic flag_problem(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    // whole 12-bit address enters the fill byte
    function automatic logic [7:0] init_byte(input int a);
        logic [11:0] ab;
        ab = a[11:0];
        return ab[7:0] ^ {ab[11:8], ab[11:8]};
    endfunction

    function automatic dcache_pkg::word_t gold_word(input dcache_pkg::addr_t a);
        dcache_pkg::word_t w;
        for (int b = 0; b < 4; b++) begin
            w[b*8 +: 8] = gold[a[11:0] + b];
        end
        return w;
    endfunction

    function automatic dcache_pkg::line_t gold_line(input dcache_pkg::addr_t a);
        dcache_pkg::line_t l;
        for (int b = 0; b < 16; b++) begin
            l[b*8 +: 8] = gold[{a[11:4], 4'h0} + b];
        end
        return l;
    endfunction

    function automatic dcache_pkg::line_t mem_line(input dcache_pkg::addr_t a);
        dcache_pkg::line_t l;
        for (int b = 0; b < 16; b++) begin
            l[b*8 +: 8] = mem[{a[11:4], 4'h0} + b];
        end
        return l;
    endfunction

    task automatic apply_store(input dcache_pkg::addr_t a, input dcache_pkg::strb_t s,
                               input dcache_pkg::word_t d);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                gold[a[11:0] + b] = d[b*8 +: 8];
            end
        end
    endtask

    task automatic load_ops();
        int fd;
        int code;
        string line;
        logic [7:0] kind;
        int test;
        logic [31:0] a, s, d, e;
        n_ops = 0;
        fd = $fopen("testbench/dcache_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/dcache_input.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_ops < MAX_OPS) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%c %d %h %h %h %h", kind, test, a, s, d, e);
                    if (code == 6) begin
                        op_kind[n_ops] = kind;
                        op_test[n_ops] = test;
                        op_addr[n_ops] = a;
                        op_strb[n_ops] = s[3:0];
                        op_wdata[n_ops] = d;
                        op_expect[n_ops] = e;
                        n_ops++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // memory side: one request at a time, random ack delay
    task automatic take_mem_request();
        mem_busy = 1'b1;
        mem_wait = 1 + ($unsigned($random(seed)) % 8);
        pend_we = mem_we;
        pend_addr = mem_addr;
        pend_wdata = mem_wdata;
        if (mem_we) begin
            op_writes++;
            test_writebacks++;
            if (op_reads != 0) begin
                flag_problem("the write-back came after the refill read");
            end
            if (mem_wdata !== gold_line(mem_addr) || mem_addr[3:0] != 4'h0) begin
                flag_mismatch($sformatf("write-back to %h carries %h, golden line %h",
                    mem_addr, mem_wdata, gold_line(mem_addr)));
            end
        end else begin
            op_reads++;
            if (mem_addr !== {op_addr[cur_op][31:4], 4'h0}) begin
                flag_mismatch($sformatf("refill read of %h for an access to %h",
                    mem_addr, op_addr[cur_op]));
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            mem_ack <= 1'b0;
            mem_busy = 1'b0;
            mem_wait = 0;
        end else begin
            mem_ack <= 1'b0;
            if (mem_req) begin
                if (mem_busy) begin
                    flag_problem("a memory request arrived while another was outstanding");
                end
                take_mem_request();
            end else if (mem_busy) begin
                mem_wait--;
                if (mem_wait == 0) begin
                    mem_busy = 1'b0;
                    mem_ack <= 1'b1;
                    if (pend_we) begin
                        for (int b = 0; b < 16; b++) begin
                            mem[{pend_addr[11:4], 4'h0} + b] = pend_wdata[b*8 +: 8];
                        end
                    end else begin
                        mem_rdata <= mem_line(pend_addr);
                    end
                end
            end
        end
    end

    task automatic run_op(input int i);
        int lat;
        dcache_pkg::word_t got;
        while (!ready) begin
            @(posedge clk);
        end
        op_reads = 0;
        op_writes = 0;
        cur_op = i;
        req <= 1'b1;
        addr <= op_addr[i];
        wstrb <= op_strb[i];
        wdata <= op_wdata[i];
        @(posedge clk);
        req <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!data_ok);
        got = rdata;
        test_ops++;
        if (op_kind[i] == "L") begin
            n_loads++;
            if (got !== op_expect[i]) begin
                flag_mismatch($sformatf("test %0d load %h returned %h, expected %h",
                    op_test[i], op_addr[i], got, op_expect[i]));
            end
            if (got !== gold_word(op_addr[i])) begin
                flag_mismatch($sformatf("test %0d load %h returned %h, golden word %h",
                    op_test[i], op_addr[i], got, gold_word(op_addr[i])));
            end
        end else begin
            apply_store(op_addr[i], op_strb[i], op_wdata[i]);
        end
        // cold misses fetch once, resident lines never touch memory
        if (op_test[i] == 1 || (op_test[i] == 4 && op_kind[i] == "S")) begin
            if (op_reads != 1 || op_writes != 0) begin
                flag_problem($sformatf("miss on %h made %0d reads and %0d writes, not one read",
                    op_addr[i], op_reads, op_writes));
            end
        end
        if (op_test[i] == 2 || op_test[i] == 3 || (op_test[i] == 4 && op_kind[i] == "L")) begin
            if (lat != 1 || op_reads != 0 || op_writes != 0) begin
                flag_problem($sformatf("hit on %h took %0d cycles with %0d memory requests",
                    op_addr[i], lat, op_reads + op_writes));
            end
        end
    endtask

    task automatic close_test(input int t);
        if (t == 5 && test_writebacks == 0) begin
            flag_problem("three tags in one set caused no write-back of a dirty line");
        end
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d finished: %0d operations, ok", t, test_ops);
        end else begin
            tests_failed++;
            $display("test %0d finished: %0d operations, %0d errors", t, test_ops, test_errors);
        end
        test_ops = 0;
        test_errors = 0;
        test_writebacks = 0;
    endtask

    initial begin
        rst = 1'b1;
        req = 1'b0;
        addr = '0;
        wstrb = '0;
        wdata = '0;
        mem_ack = 1'b0;
        mem_rdata = '0;
        load_ops();
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = init_byte(a);
            gold[a] = init_byte(a);
        end
        cycle_limit = n_ops * CYCLES_PER_OP + 20;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (!ready || data_ok || mem_req) begin
            flag_problem("outputs after reset are not idle");
        end
        for (int i = 0; i < n_ops; i++) begin
            if (i > 0 && op_test[i] != op_test[i-1]) begin
                close_test(op_test[i-1]);
            end
            run_op(i);
        end
        if (n_ops > 0) begin
            close_test(op_test[n_ops-1]);
        end
        // checker sees the final edge
        @(posedge clk);
        if (u_dcache_top.u_dcache_checker.fail_cnt != 0) begin
            $display("protocol assertions failed %0d times",
                u_dcache_top.u_dcache_checker.fail_cnt);
            errors += int'(u_dcache_top.u_dcache_checker.fail_cnt);
        end
        $display("tests passed %0d, failed %0d, loads checked %0d, errors %0d",
            tests_passed, tests_failed, n_loads, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
